/* addSubUnit.f */
hdl/claPkg.sv
hdl/aluPkg.sv
hdl/claGroup4.sv
hdl/claBlock.sv
hdl/claAdder.sv
hdl/addSubUnit.sv
dv/tbClock.sv
dv/addSubUnitTb.sv

/* dv/addSubUnitTb.sv */
module addSubUnitTb;
  timeunit 1ns;
  timeprecision 1ps;

  import aluPkg::*;

  localparam int unsigned Msb        = DataBits - 1;
  localparam int unsigned RandomOps  = 150;
  localparam int unsigned BackToBack = 200;
  localparam int unsigned DrainLimit = 50;
  localparam int unsigned ResetLimit = 20;

  logic clk;
  logic arstN;
  reqT  req;
  logic reqStrobe;
  rspT  rsp;
  logic rspStrobe;

  // Expected responses and the cycle each one is due
  rspT         expQ[$];
  int unsigned dueQ[$];
  int unsigned cycleCnt;
  int unsigned reqCount;

  tbClock #(
    .PeriodNs    (40),
    .ResetCycles (2)
  ) u_tbClock (
    .clk   (clk),
    .arstN (arstN)
  );

  addSubUnit #(
    .DataBits  (DataBits),
    .NumGroups (4)
  ) u_addSubUnit (
    .clk       (clk),
    .arstN     (arstN),
    .req       (req),
    .reqStrobe (reqStrobe),
    .rsp       (rsp),
    .rspStrobe (rspStrobe)
  );

  initial cycleCnt = 0;

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
  end

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic rspT expectedRsp(input reqT r);
    logic [DataBits:0] wide;
    rspT               e;
    if (r.op == OpAdd) begin
      wide             = {1'b0, r.opA} + {1'b0, r.opB};
      e.flags.carry    = wide[DataBits];
      e.flags.overflow = (r.opA[Msb] == r.opB[Msb]) && (wide[Msb] != r.opA[Msb]);
    end else begin
      wide             = {1'b0, r.opA} - {1'b0, r.opB};
      // No borrow
      e.flags.carry    = (r.opA >= r.opB);
      e.flags.overflow = (r.opA[Msb] != r.opB[Msb]) && (wide[Msb] != r.opA[Msb]);
    end
    e.result         = wide[DataBits-1:0];
    e.flags.zero     = (e.result == '0);
    e.flags.negative = e.result[Msb];
    return e;
  endfunction

  function automatic logic [DataBits-1:0] randOperand();
    int unsigned pick;
    pick = $urandom_range(0, 11);
    case (pick)
      0:       return '0;
      1:       return 32'h0000_0001;
      2:       return '1;
      3:       return 32'h7FFF_FFFF;
      4:       return 32'h8000_0000;
      5:       return 32'h0000_FFFF;
      default: return $urandom;
    endcase
  endfunction

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------

  task automatic issue(input logic [DataBits-1:0] a, input logic [DataBits-1:0] b,
                       input opT op);
    reqT r;
    r.opA = a;
    r.opB = b;
    r.op  = op;
    @(negedge clk);
    req       = r;
    reqStrobe = 1'b1;
    expQ.push_back(expectedRsp(r));
    dueQ.push_back(cycleCnt + 2);
    reqCount++;
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(negedge clk);
      reqStrobe = 1'b0;
      req       = '0;
    end
  endtask

  task automatic waitReset();
    int unsigned n;
    n = 0;
    while (arstN !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > ResetLimit) failRun("reset was never released");
    end
  endtask

  task automatic waitDrain();
    int unsigned n;
    n = 0;
    while (expQ.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > DrainLimit) failRun("timed out waiting for outstanding responses");
    end
  endtask

  // ----------------------------------------
  // Checking at the falling edge
  // ----------------------------------------

  always @(negedge clk) begin
    if (arstN) begin
      if (reqCount == 0) begin
        assert (!rspStrobe && rsp == '0)
          else failRun($sformatf("mismatch at %0t: output active before any request",
                                 $time));
      end
      if (rspStrobe) begin
        assert (expQ.size() > 0)
          else failRun("response strobe seen with no request in flight");
        assert (dueQ[0] == cycleCnt)
          else failRun($sformatf("mismatch at %0t: response in cycle %0d, due in %0d",
                                 $time, cycleCnt, dueQ[0]));
        assert (rsp.result == expQ[0].result)
          else failRun($sformatf("mismatch at %0t: result %08h, expected %08h",
                                 $time, rsp.result, expQ[0].result));
        assert (rsp.flags == expQ[0].flags)
          else failRun($sformatf("mismatch at %0t: flags cvzn %04b, expected %04b",
                                 $time, rsp.flags, expQ[0].flags));
        expQ.pop_front();
        dueQ.pop_front();
      end else if (expQ.size() > 0) begin
        assert (dueQ[0] > cycleCnt)
          else failRun($sformatf("mismatch at %0t: no response in cycle %0d",
                                 $time, dueQ[0]));
      end
    end
  end

  initial begin
    int unsigned seed;
    int unsigned gap;
    logic [DataBits-1:0] a;
    seed      = $urandom(29);
    req       = '0;
    reqStrobe = 1'b0;
    reqCount  = 0;
    waitReset();
    idle(5);

    // Carry chains across group and block boundaries
    issue('1, 32'h0000_0001, OpAdd);
    issue(32'h0000_000F, 32'h0000_0001, OpAdd);
    issue(32'h0000_FFFF, 32'h0000_0001, OpAdd);
    issue(32'h0FFF_FFFF, 32'h0000_0001, OpAdd);
    issue(32'h5555_5555, 32'hAAAA_AAAB, OpAdd);
    issue(32'h8000_0000, 32'h8000_0000, OpAdd);
    issue('1, '1, OpAdd);
    // Signed corners
    issue(32'h7FFF_FFFF, 32'h0000_0001, OpAdd);
    issue(32'h8000_0000, 32'h0000_0001, OpSub);
    issue(32'h1234_5678, 32'h1234_5678, OpSub);
    issue(32'h0000_0000, 32'h0000_0001, OpSub);
    issue(32'h0000_0000, 32'h0000_0000, OpSub);
    idle(1);
    waitDrain();

    // Random additions, then subtractions, with random gaps
    repeat (RandomOps) begin
      issue(randOperand(), randOperand(), OpAdd);
      gap = $urandom_range(0, 4);
      idle(gap);
    end
    repeat (RandomOps) begin
      a = randOperand();
      if ($urandom_range(0, 7) == 0) begin
        issue(a, a, OpSub);
      end else begin
        issue(a, randOperand(), OpSub);
      end
      gap = $urandom_range(0, 4);
      idle(gap);
    end
    idle(1);
    waitDrain();

    // One request every cycle
    repeat (BackToBack) begin
      issue(randOperand(), randOperand(), $urandom_range(0, 1) ? OpSub : OpAdd);
    end
    idle(1);
    waitDrain();
    idle(10);

    $display("Test OK");
    $finish;
  end

endmodule

/* dv/tbClock.sv */
module tbClock #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 2
) (
  output logic clk,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  // Release away from the active edge
  initial begin
    arstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
  end

endmodule

/* hdl/addSubUnit.sv */
module addSubUnit #(
  parameter int unsigned DataBits  = aluPkg::DataBits,
  parameter int unsigned NumGroups = 4
) (
  input  logic        clk,
  input  logic        arstN,
  input  aluPkg::reqT req,
  input  logic        reqStrobe,
  output aluPkg::rspT rsp,
  output logic        rspStrobe
);
  import aluPkg::*;
  import claPkg::*;

  localparam int unsigned NumBlocks = DataBits / (NumGroups * GroupBits);
  localparam int unsigned Msb       = DataBits - 1;

  logic                s1Valid;
  logic [DataBits-1:0] s1A;
  logic [DataBits-1:0] s1B;
  logic                s1CarryIn;

  logic [DataBits-1:0] sum;
  logic                carryOut;
  flagsT               nextFlags;

  // ----------------------------------------
  // Stage 1 operand conditioning
  // ----------------------------------------

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= reqStrobe;
    end
  end

  // Subtract as A + ~B + 1
  always_ff @(posedge clk) begin
    if (reqStrobe) begin
      s1A       <= req.opA;
      s1B       <= (req.op == OpSub) ? ~req.opB : req.opB;
      s1CarryIn <= (req.op == OpSub);
    end
  end

  // ----------------------------------------
  // Adder and flags
  // ----------------------------------------

  claAdder #(
    .NumBlocks (NumBlocks),
    .NumGroups (NumGroups)
  ) u_claAdder (
    .aIn      (s1A),
    .bIn      (s1B),
    .carryIn  (s1CarryIn),
    .sum      (sum),
    .carryOut (carryOut)
  );

  always_comb begin
    nextFlags.carry    = carryOut;
    nextFlags.zero     = (sum == '0);
    nextFlags.negative = sum[Msb];
    // Signed overflow from the conditioned inputs
    nextFlags.overflow = (s1A[Msb] == s1B[Msb]) && (sum[Msb] != s1A[Msb]);
  end

  // ----------------------------------------
  // Stage 2 result register
  // ----------------------------------------

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rsp       <= '0;
      rspStrobe <= 1'b0;
    end else begin
      rspStrobe <= s1Valid;
      if (s1Valid) begin
        rsp.result <= sum;
        rsp.flags  <= nextFlags;
      end
    end
  end

endmodule

/* hdl/aluPkg.sv */
package aluPkg;

  // Operand width of the add/subtract unit
  localparam int unsigned DataBits = 32;

  // ----------------------------------------
  // Request side
  // ----------------------------------------

  typedef enum logic {
    OpAdd = 1'b0,
    OpSub = 1'b1
  } opT;

  typedef struct packed {
    logic [DataBits-1:0] opA;
    logic [DataBits-1:0] opB;
    opT                  op;
  } reqT;

  // ----------------------------------------
  // Response side
  // ----------------------------------------

  // Carry reads as "no borrow" for subtraction
  typedef struct packed {
    logic carry;
    logic overflow;
    logic zero;
    logic negative;
  } flagsT;

  typedef struct packed {
    logic [DataBits-1:0] result;
    flagsT               flags;
  } rspT;

endpackage

/* hdl/claAdder.sv */
module claAdder #(
  parameter int unsigned NumBlocks = 2,
  parameter int unsigned NumGroups = 4
) (
  input  logic [NumBlocks*NumGroups*claPkg::GroupBits-1:0] aIn,
  input  logic [NumBlocks*NumGroups*claPkg::GroupBits-1:0] bIn,
  input  logic                                             carryIn,
  output logic [NumBlocks*NumGroups*claPkg::GroupBits-1:0] sum,
  output logic                                             carryOut
);
  import claPkg::*;

  localparam int unsigned BlockBits = NumGroups * GroupBits;

  pgT   [NumBlocks-1:0] blockPg;
  logic [NumBlocks:0]   blockCarry;

  for (genvar i = 0; i < NumBlocks; i++) begin : gBlock
    claBlock #(
      .NumGroups (NumGroups)
    ) u_claBlock (
      .aIn     (aIn[i*BlockBits +: BlockBits]),
      .bIn     (bIn[i*BlockBits +: BlockBits]),
      .carryIn (blockCarry[i]),
      .sum     (sum[i*BlockBits +: BlockBits]),
      .pg      (blockPg[i])
    );
  end

  // ----------------------------------------
  // Third-level lookahead
  // ----------------------------------------

  // Top entry is the adder carry-out
  always_comb begin
    logic chainProp;
    chainProp  = 1'b1;
    blockCarry = '0;
    for (int i = 0; i <= NumBlocks; i++) begin
      chainProp = 1'b1;
      for (int j = i - 1; j >= 0; j--) begin
        blockCarry[i] = blockCarry[i] | (chainProp & blockPg[j].gen);
        chainProp     = chainProp & blockPg[j].prop;
      end
      blockCarry[i] = blockCarry[i] | (chainProp & carryIn);
    end
  end

  assign carryOut = blockCarry[NumBlocks];

endmodule

/* hdl/claBlock.sv */
module claBlock #(
  parameter int unsigned NumGroups = 4
) (
  input  logic [NumGroups*claPkg::GroupBits-1:0] aIn,
  input  logic [NumGroups*claPkg::GroupBits-1:0] bIn,
  input  logic                                   carryIn,
  output logic [NumGroups*claPkg::GroupBits-1:0] sum,
  output claPkg::pgT                             pg
);
  import claPkg::*;

  pgT   [NumGroups-1:0] groupPg;
  logic [NumGroups-1:0] groupCarry;

  // ----------------------------------------
  // Groups
  // ----------------------------------------

  for (genvar i = 0; i < NumGroups; i++) begin : gGroup
    claGroup4 u_claGroup4 (
      .aIn     (aIn[i*GroupBits +: GroupBits]),
      .bIn     (bIn[i*GroupBits +: GroupBits]),
      .carryIn (groupCarry[i]),
      .sum     (sum[i*GroupBits +: GroupBits]),
      .pg      (groupPg[i])
    );
  end

  // ----------------------------------------
  // Second-level lookahead
  // ----------------------------------------

  // Carry into group i is the OR of each lower generate and the block carry-in,
  // each masked by the propagates between it and group i
  always_comb begin
    logic chainProp;
    chainProp  = 1'b1;
    groupCarry = '0;
    for (int i = 0; i < NumGroups; i++) begin
      chainProp = 1'b1;
      for (int j = i - 1; j >= 0; j--) begin
        groupCarry[i] = groupCarry[i] | (chainProp & groupPg[j].gen);
        chainProp     = chainProp & groupPg[j].prop;
      end
      groupCarry[i] = groupCarry[i] | (chainProp & carryIn);
    end
  end

  // Block pair uses the same terms over all groups without the carry-in
  always_comb begin
    logic chainProp;
    logic blockGen;
    chainProp = 1'b1;
    blockGen  = 1'b0;
    for (int j = NumGroups - 1; j >= 0; j--) begin
      blockGen  = blockGen | (chainProp & groupPg[j].gen);
      chainProp = chainProp & groupPg[j].prop;
    end
    pg.prop = chainProp;
    pg.gen  = blockGen;
  end

endmodule

/* hdl/claGroup4.sv */
module claGroup4 (
  input  logic [claPkg::GroupBits-1:0] aIn,
  input  logic [claPkg::GroupBits-1:0] bIn,
  input  logic                         carryIn,
  output logic [claPkg::GroupBits-1:0] sum,
  output claPkg::pgT                   pg
);
  import claPkg::*;

  logic [GroupBits-1:0] bitProp;
  logic [GroupBits-1:0] bitGen;
  logic [GroupBits-1:0] carry;

  // Per-bit propagate and generate
  assign bitProp = aIn ^ bIn;
  assign bitGen  = aIn & bIn;

  // ----------------------------------------
  // Internal carries, one lookahead step
  // ----------------------------------------

  assign carry[0] = carryIn;
  assign carry[1] = bitGen[0]
                  | (bitProp[0] & carryIn);
  assign carry[2] = bitGen[1]
                  | (bitProp[1] & bitGen[0])
                  | (bitProp[1] & bitProp[0] & carryIn);
  assign carry[3] = bitGen[2]
                  | (bitProp[2] & bitGen[1])
                  | (bitProp[2] & bitProp[1] & bitGen[0])
                  | (bitProp[2] & bitProp[1] & bitProp[0] & carryIn);

  assign sum = bitProp ^ carry;

  // ----------------------------------------
  // Group pair for the next level
  // ----------------------------------------

  assign pg.prop = &bitProp;
  assign pg.gen  = bitGen[3]
                 | (bitProp[3] & bitGen[2])
                 | (bitProp[3] & bitProp[2] & bitGen[1])
                 | (bitProp[3] & bitProp[2] & bitProp[1] & bitGen[0]);

endmodule

/* hdl/claPkg.sv */
package claPkg;

  // ----------------------------------------
  // Lookahead geometry
  // ----------------------------------------

  // Bits covered by one lookahead group
  localparam int unsigned GroupBits = 4;

  // ----------------------------------------
  // Propagate/generate pair
  // ----------------------------------------

  // Passed up from group to block and from block to adder.
  // Every level uses the same carry rule:
  //   carry out = gen | (prop & carry in)
  typedef struct packed {
    logic prop;
    logic gen;
  } pgT;

endpackage

/* runSim.sh */
#!/bin/sh
# Build and run the add/subtract unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
  --top-module addSubUnitTb \
  -f addSubUnit.f \
  -o simv > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/simv > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$SIM_LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

exit 0
